// File: dphy_rx_pkg.sv
`default_nettype none

package dphy_rx_pkg;

  // Lane configuration
  localparam int NUM_LANES = 2;

  // HS sync pattern sent LSB first on the wire
  localparam logic [7:0] SYNC_BYTE = 8'hB8;

  // Bytes of HS data ignored after the lane enters LP-00
  localparam int SETTLE_BYTES = 6;

  // Largest lead of one lane over another before deskew gives up
  localparam int MAX_SKEW = 3;

  // Per-lane deskew FIFO depth
  localparam int DESKEW_DEPTH = 4;

  // Derived widths
  localparam int SETTLE_CNT_W = $clog2(SETTLE_BYTES + 1);
  localparam int FIFO_PTR_W   = $clog2(DESKEW_DEPTH);
  localparam int FIFO_CNT_W   = $clog2(DESKEW_DEPTH + 1);
  localparam int SKEW_CNT_W   = $clog2(MAX_SKEW + 1);
  localparam int RX_WORD_W    = 32;

  // One byte per lane, lane 0 in the low byte
  typedef logic [NUM_LANES-1:0][7:0] lane_bytes_t;

  // Deskewed bytes of all lanes taken in the same cycle
  typedef struct packed {
    lane_bytes_t data;
    logic        valid;
  } lane_word_t;

  // Output word of the receive path
  typedef struct packed {
    logic [RX_WORD_W-1:0] data;
    logic                 valid;
  } rx_word_t;

  // Byte aligner states
  typedef enum logic [1:0] {
    ALIGN_IDLE,
    ALIGN_HUNT,
    ALIGN_LOCKED
  } align_state_t;

endpackage

`default_nettype wire

// File: dphy_settle_ignore.sv
`default_nettype none

module dphy_settle_ignore (
  input  logic byte_clk,
  input  logic arst_n_i,
  input  logic lp_p_i,
  input  logic lp_n_i,
  output logic hs_valid_o
);

import dphy_rx_pkg::*;

// Synchroniser stages holding {p, n}
logic [1:0]              lp_meta;
logic [1:0]              lp_sync;
logic                    lp_00;
logic [SETTLE_CNT_W-1:0] settle_cnt;

// Lines idle in the stop state (LP-11) after reset
always_ff @( posedge byte_clk, negedge arst_n_i )
  if( !arst_n_i )
    begin
      lp_meta <= 2'b11;
      lp_sync <= 2'b11;
    end
  else
    begin
      lp_meta <= {lp_p_i, lp_n_i};
      lp_sync <= lp_meta;
    end

assign lp_00 = ( lp_sync == 2'b00 );

// Count settle bytes in LP-00 and drop valid on any other line state
always_ff @( posedge byte_clk, negedge arst_n_i )
  if( !arst_n_i )
    begin
      settle_cnt <= '0;
      hs_valid_o <= 1'b0;
    end
  else if( !lp_00 )
    begin
      settle_cnt <= '0;
      hs_valid_o <= 1'b0;
    end
  else if( !hs_valid_o )
    begin
      settle_cnt <= settle_cnt + 1'b1;
      // Last settle byte seen
      if( settle_cnt == SETTLE_CNT_W'( SETTLE_BYTES - 1 ) )
        hs_valid_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: dphy_byte_align.sv
`default_nettype none

module dphy_byte_align (
  input  logic       byte_clk,
  input  logic       arst_n_i,
  input  logic [7:0] unaligned_byte_i,
  input  logic       hs_valid_i,
  input  logic       reset_align_i,
  input  logic       pkt_end_i,
  output logic [7:0] aligned_byte_o,
  output logic       valid_o
);

import dphy_rx_pkg::*;

align_state_t state;
align_state_t state_next;

// Two-byte view of the bit stream, older byte in the low half
logic [7:0]  prev_byte;
logic [15:0] window;

logic [2:0]  match_offset;
logic        match_found;
logic [2:0]  lock_offset;

logic        hs_valid_q;
logic        hs_rise;
logic        drop_lock;

always_ff @( posedge byte_clk )
  prev_byte <= unaligned_byte_i;

assign window = {unaligned_byte_i, prev_byte};

// Lowest matching offset wins, so scan from the top down
always_comb
  begin
    match_found  = 1'b0;
    match_offset = '0;
    for( int i = 7; i >= 0; i-- )
      if( window[i +: 8] == SYNC_BYTE )
        begin
          match_found  = 1'b1;
          match_offset = 3'( i );
        end
  end

// Hunting starts only on a fresh HS burst
assign hs_rise   = hs_valid_i && !hs_valid_q;
assign drop_lock = !hs_valid_i || reset_align_i || pkt_end_i;

always_comb
  begin
    state_next = state;
    case( state )
      ALIGN_IDLE:
        if( hs_rise && !reset_align_i )
          state_next = ALIGN_HUNT;
      ALIGN_HUNT:
        if( drop_lock )
          state_next = ALIGN_IDLE;
        else if( match_found )
          state_next = ALIGN_LOCKED;
      ALIGN_LOCKED:
        if( drop_lock )
          state_next = ALIGN_IDLE;
      default:
        state_next = ALIGN_IDLE;
    endcase
  end

always_ff @( posedge byte_clk, negedge arst_n_i )
  if( !arst_n_i )
    begin
      state      <= ALIGN_IDLE;
      hs_valid_q <= 1'b0;
    end
  else
    begin
      state      <= state_next;
      hs_valid_q <= hs_valid_i;
    end

// Offset is captured together with the sync byte itself
always_ff @( posedge byte_clk, negedge arst_n_i )
  if( !arst_n_i )
    lock_offset <= '0;
  else if( state == ALIGN_HUNT && match_found && !drop_lock )
    lock_offset <= match_offset;

// Sync byte is never output and streaming starts with the byte after it
always_ff @( posedge byte_clk, negedge arst_n_i )
  if( !arst_n_i )
    valid_o <= 1'b0;
  else
    valid_o <= ( state == ALIGN_LOCKED ) && !drop_lock;

always_ff @( posedge byte_clk )
  aligned_byte_o <= window[lock_offset +: 8];

endmodule

`default_nettype wire

// File: dphy_word_align.sv
`default_nettype none

module dphy_word_align (
  input  logic                              byte_clk,
  input  logic                              arst_n_i,
  input  dphy_rx_pkg::lane_bytes_t          byte_i,
  input  logic [dphy_rx_pkg::NUM_LANES-1:0] valid_i,
  input  logic                              pkt_end_i,
  output dphy_rx_pkg::lane_word_t           word_o,
  output logic                              reset_align_o
);

import dphy_rx_pkg::*;

logic [7:0]                           fifo_mem [NUM_LANES][DESKEW_DEPTH];
logic [NUM_LANES-1:0][FIFO_PTR_W-1:0] wr_ptr;
logic [NUM_LANES-1:0][FIFO_PTR_W-1:0] rd_ptr;
logic [NUM_LANES-1:0][FIFO_CNT_W-1:0] fill;
logic [NUM_LANES-1:0][SKEW_CNT_W-1:0] wait_cnt;

logic [NUM_LANES-1:0] not_empty;
logic [NUM_LANES-1:0] push;
logic [NUM_LANES-1:0] lane_late;
logic                 all_ready;
logic                 skew_det;
logic                 flush;
lane_bytes_t          head;
lane_bytes_t          out_data;
logic                 out_valid;

function automatic logic [FIFO_PTR_W-1:0] ptr_inc( input logic [FIFO_PTR_W-1:0] ptr );
  if( ptr == FIFO_PTR_W'( DESKEW_DEPTH - 1 ) )
    return '0;
  return ptr + 1'b1;
endfunction

always_comb
  for( int i = 0; i < NUM_LANES; i++ )
    begin
      not_empty[i] = ( fill[i] != '0 );
      head[i]      = fifo_mem[i][rd_ptr[i]];
    end

// One byte leaves every lane together
assign all_ready = &not_empty;

always_comb
  for( int i = 0; i < NUM_LANES; i++ )
    begin
      push[i]      = valid_i[i] && ( fill[i] != FIFO_CNT_W'( DESKEW_DEPTH ) || all_ready );
      // Lane has waited MAX_SKEW cycles and still another lane is empty
      lane_late[i] = not_empty[i] && !all_ready &&
                     ( wait_cnt[i] == SKEW_CNT_W'( MAX_SKEW ) );
    end

assign skew_det = |lane_late;

// Keep flushing while the aligners see the reset pulse
assign flush = skew_det || reset_align_o || pkt_end_i;

always_ff @( posedge byte_clk, negedge arst_n_i )
  if( !arst_n_i )
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      wait_cnt <= '0;
    end
  else
    for( int i = 0; i < NUM_LANES; i++ )
      if( flush )
        begin
          wr_ptr[i]   <= '0;
          rd_ptr[i]   <= '0;
          fill[i]     <= '0;
          wait_cnt[i] <= '0;
        end
      else
        begin
          if( push[i] )
            wr_ptr[i] <= ptr_inc( wr_ptr[i] );
          if( all_ready )
            rd_ptr[i] <= ptr_inc( rd_ptr[i] );
          fill[i] <= fill[i] + FIFO_CNT_W'( push[i] ) - FIFO_CNT_W'( all_ready );
          if( not_empty[i] && !all_ready )
            wait_cnt[i] <= wait_cnt[i] + 1'b1;
          else
            wait_cnt[i] <= '0;
        end

always_ff @( posedge byte_clk )
  for( int i = 0; i < NUM_LANES; i++ )
    if( push[i] )
      fifo_mem[i][wr_ptr[i]] <= byte_i[i];

always_ff @( posedge byte_clk, negedge arst_n_i )
  if( !arst_n_i )
    begin
      out_valid     <= 1'b0;
      reset_align_o <= 1'b0;
    end
  else
    begin
      out_valid     <= all_ready && !flush;
      reset_align_o <= skew_det;
    end

always_ff @( posedge byte_clk )
  if( all_ready )
    out_data <= head;

assign word_o.data  = out_data;
assign word_o.valid = out_valid;

endmodule

`default_nettype wire

// File: dphy_32b_map.sv
`default_nettype none

module dphy_32b_map (
  input  logic                    byte_clk,
  input  logic                    arst_n_i,
  input  dphy_rx_pkg::lane_word_t word_i,
  input  logic                    pkt_end_i,
  output dphy_rx_pkg::rx_word_t   word_o
);

import dphy_rx_pkg::*;

// High when the holding register has the first half of a word
logic                 phase;
lane_bytes_t          hold;
logic [RX_WORD_W-1:0] out_data;
logic                 out_valid;

always_ff @( posedge byte_clk, negedge arst_n_i )
  if( !arst_n_i )
    phase <= 1'b0;
  else if( pkt_end_i )
    phase <= 1'b0;
  else if( word_i.valid )
    phase <= !phase;

// Half word is dropped at packet end
always_ff @( posedge byte_clk )
  if( pkt_end_i )
    hold <= '0;
  else if( word_i.valid && !phase )
    hold <= word_i.data;

// A word completed in the packet end cycle is still delivered
always_ff @( posedge byte_clk, negedge arst_n_i )
  if( !arst_n_i )
    out_valid <= 1'b0;
  else
    out_valid <= word_i.valid && phase;

// First lane word in time goes to the low half
always_ff @( posedge byte_clk )
  if( word_i.valid && phase )
    out_data <= {word_i.data, hold};

assign word_o.data  = out_data;
assign word_o.valid = out_valid;

endmodule

`default_nettype wire

// File: dphy_rx_core.sv
`default_nettype none

module dphy_rx_core (
  input  logic                              byte_clk,
  input  logic                              arst_n_i,
  input  dphy_rx_pkg::lane_bytes_t          lane_byte_i,
  input  logic [dphy_rx_pkg::NUM_LANES-1:0] lp_p_i,
  input  logic [dphy_rx_pkg::NUM_LANES-1:0] lp_n_i,
  input  logic                              pkt_end_i,
  output dphy_rx_pkg::rx_word_t             word_o,
  output logic                              skew_err_o
);

import dphy_rx_pkg::*;

// Per-lane HS data qualifier after settle time
logic [NUM_LANES-1:0] hs_valid;
// Realigned bytes from the aligners
lane_bytes_t          aligned_byte;
logic [NUM_LANES-1:0] aligned_valid;
// Deskew failure restarts every aligner
logic                 reset_align;
lane_word_t           lane_word;

generate
  for( genvar i = 0; i < NUM_LANES; i++ )
    begin : lane
      dphy_settle_ignore settle_ignore (
        .byte_clk   ( byte_clk    ),
        .arst_n_i   ( arst_n_i    ),
        .lp_p_i     ( lp_p_i[i]   ),
        .lp_n_i     ( lp_n_i[i]   ),
        .hs_valid_o ( hs_valid[i] )
      );

      dphy_byte_align byte_align (
        .byte_clk         ( byte_clk         ),
        .arst_n_i         ( arst_n_i         ),
        .unaligned_byte_i ( lane_byte_i[i]   ),
        .hs_valid_i       ( hs_valid[i]      ),
        .reset_align_i    ( reset_align      ),
        .pkt_end_i        ( pkt_end_i        ),
        .aligned_byte_o   ( aligned_byte[i]  ),
        .valid_o          ( aligned_valid[i] )
      );
    end
endgenerate

dphy_word_align word_align (
  .byte_clk      ( byte_clk      ),
  .arst_n_i      ( arst_n_i      ),
  .byte_i        ( aligned_byte  ),
  .valid_i       ( aligned_valid ),
  .pkt_end_i     ( pkt_end_i     ),
  .word_o        ( lane_word     ),
  .reset_align_o ( reset_align   )
);

dphy_32b_map mapper (
  .byte_clk  ( byte_clk  ),
  .arst_n_i  ( arst_n_i  ),
  .word_i    ( lane_word ),
  .pkt_end_i ( pkt_end_i ),
  .word_o    ( word_o    )
);

assign skew_err_o = reset_align;

endmodule

`default_nettype wire

// File: tb_dphy_rx_core.sv
`default_nettype none

module tb_dphy_rx_core;

timeunit 1ns;
timeprecision 1ps;

import dphy_rx_pkg::*;

localparam int          CLK_PERIOD   = 40;
localparam int          RESET_CYCLES = 16;
localparam int          NUM_ROWS     = 15;
localparam logic [31:0] SEED         = 32'd80536;
// Idle byte slots before the earliest LP-00 of a row
localparam int          LEAD         = 2;
localparam int          LP_TO_SYNC   = SETTLE_BYTES + 4;
// LP-00 length of a burst that ends before the settle time
localparam int          SHORT_LP     = 3;
// Aligner plus deskew latency, wire slot to mapper input
localparam int          PKT_END_LAG  = 4;
localparam int          TAIL         = 12;

typedef struct packed {
  logic [NUM_LANES-1:0][2:0] off;
  logic [NUM_LANES-1:0][3:0] dly;
  logic [3:0]                n_words;
  logic                      lp_short;
  logic                      pkt_mid;
  logic [3:0]                exp_words;
  logic [1:0]                exp_skew;
} row_t;

logic                 byte_clk = 1'b0;
logic                 arst_n_i;
lane_bytes_t          lane_byte_i;
logic [NUM_LANES-1:0] lp_p_i;
logic [NUM_LANES-1:0] lp_n_i;
logic                 pkt_end_i;
rx_word_t             word_o;
logic                 skew_err_o;

logic [31:0] rng_state;
logic [7:0]  payload [$];
logic [31:0] exp_q [$];
int          words_seen;
int          skews_seen;

dphy_rx_core dphy_rx_core_i (
  .byte_clk    ( byte_clk    ),
  .arst_n_i    ( arst_n_i    ),
  .lane_byte_i ( lane_byte_i ),
  .lp_p_i      ( lp_p_i      ),
  .lp_n_i      ( lp_n_i      ),
  .pkt_end_i   ( pkt_end_i   ),
  .word_o      ( word_o      ),
  .skew_err_o  ( skew_err_o  )
);

always
  #( CLK_PERIOD / 2 ) byte_clk = ~byte_clk;

function automatic logic [31:0] xorshift32( input logic [31:0] x );
  logic [31:0] y;
  y = x ^ ( x << 13 );
  y = y ^ ( y >> 17 );
  y = y ^ ( y << 5 );
  return y;
endfunction

function automatic row_t make_row( input int off0, input int off1, input int dly0,
                                   input int dly1, input int words, input int lp_short,
                                   input int pkt_mid, input int exp_words, input int exp_skew );
  row_t row;
  row.off[0]    = 3'( off0 );
  row.off[1]    = 3'( off1 );
  row.dly[0]    = 4'( dly0 );
  row.dly[1]    = 4'( dly1 );
  row.n_words   = 4'( words );
  row.lp_short  = 1'( lp_short );
  row.pkt_mid   = 1'( pkt_mid );
  row.exp_words = 4'( exp_words );
  row.exp_skew  = 2'( exp_skew );
  return row;
endfunction

// Columns are off0 off1 dly0 dly1 words lp_short pkt_mid exp_words exp_skew
function automatic row_t row_at( input int r );
  case( r )
    0:  return make_row( 0, 0, 0, 0, 4, 0, 0, 4, 0 );
    1:  return make_row( 1, 2, 0, 0, 3, 0, 0, 3, 0 );
    2:  return make_row( 3, 4, 0, 0, 3, 0, 0, 3, 0 );
    3:  return make_row( 5, 6, 0, 0, 3, 0, 0, 3, 0 );
    4:  return make_row( 7, 0, 0, 0, 3, 0, 0, 3, 0 );
    // Skew within MAX_SKEW
    5:  return make_row( 2, 5, 1, 0, 4, 0, 0, 4, 0 );
    6:  return make_row( 6, 3, 0, 2, 4, 0, 0, 4, 0 );
    7:  return make_row( 4, 1, 3, 0, 4, 0, 0, 4, 0 );
    8:  return make_row( 0, 7, 0, 3, 3, 0, 0, 3, 0 );
    // Skew beyond MAX_SKEW gives one error pulse and no words
    9:  return make_row( 1, 6, 0, 4, 3, 0, 0, 0, 1 );
    10: return make_row( 3, 2, 5, 0, 3, 0, 0, 0, 1 );
    11: return make_row( 5, 5, 0, 0, 3, 1, 0, 0, 0 );
    // Packet end in the middle of word n_words/2
    12: return make_row( 2, 7, 0, 0, 4, 0, 1, 2, 0 );
    13: return make_row( 6, 1, 0, 0, 5, 0, 1, 2, 0 );
    14: return make_row( 0, 0, 0, 0, 2, 0, 0, 2, 0 );
    default: return '0;
  endcase
endfunction

function automatic int row_slots( input row_t row );
  int dly_max;
  dly_max = ( row.dly[0] > row.dly[1] ) ? row.dly[0] : row.dly[1];
  return LEAD + LP_TO_SYNC + dly_max + row.n_words * 4 / NUM_LANES + TAIL;
endfunction

// Serial lane model of zeros, sync byte and lane payload sent LSB first and cut into slots
function automatic logic [7:0] slot_byte( input int lane, input int slot, input int sync_pos,
                                          input int nb );
  logic [7:0] b;
  logic [7:0] pb;
  int         rel;
  int         idx;
  for( int i = 0; i < 8; i++ )
    begin
      rel = 8 * slot + i - sync_pos;
      idx = ( rel < 0 ) ? -1 : rel / 8;
      if( idx == 0 )
        b[i] = SYNC_BYTE[rel % 8];
      else if( idx >= 1 && idx <= nb )
        begin
          pb   = payload[NUM_LANES * ( idx - 1 ) + lane];
          b[i] = pb[rel % 8];
        end
      else
        b[i] = 1'b0;
    end
  return b;
endfunction

task automatic stop_with_error( input string line );
  $display( "%s", line );
  $display( "TEST FAILED" );
  $fatal( 1, "Simulation stopped at the first error" );
endtask

task automatic check_word( input rx_word_t got );
  logic [31:0] exp;
  if( exp_q.size() == 0 )
    stop_with_error( $sformatf( "CHECK FAILED at %0t ns: unexpected word %08h on word_o",
                                $time, got.data ) );
  else
    begin
      exp = exp_q.pop_front();
      if( got.data !== exp )
        stop_with_error( $sformatf( "CHECK FAILED at %0t ns: word_o %08h, expected %08h",
                                    $time, got.data, exp ) );
      words_seen++;
    end
endtask

task automatic check_count( input int row, input int got, input int exp, input string what );
  if( got != exp )
    stop_with_error( $sformatf( "CHECK FAILED at %0t ns: row %0d saw %0d %s, expected %0d",
                                $time, row, got, what, exp ) );
endtask

task automatic apply_row( input int r );
  row_t row;
  int   nb;
  int   pkt_slot;
  int   k [NUM_LANES];
  int   sync_pos [NUM_LANES];
  int   lp_on [NUM_LANES];
  int   lp_off [NUM_LANES];
  row = row_at( r );
  nb  = row.n_words * 4 / NUM_LANES;
  payload.delete();
  for( int i = 0; i < row.n_words * 4; i++ )
    begin
      rng_state = xorshift32( rng_state );
      payload.push_back( rng_state[7:0] );
    end
  // Bytes 4w to 4w+3 form expected word w with the lowest byte in the low bits
  for( int w = 0; w < row.exp_words; w++ )
    exp_q.push_back( {payload[4*w+3], payload[4*w+2], payload[4*w+1], payload[4*w]} );
  words_seen = 0;
  skews_seen = 0;
  for( int l = 0; l < NUM_LANES; l++ )
    begin
      k[l]        = LEAD + LP_TO_SYNC + row.dly[l];
      sync_pos[l] = 8 * k[l] + row.off[l];
      lp_on[l]    = k[l] - LP_TO_SYNC;
      // Synchronised lines leave LP-00 just as the last payload byte is taken
      lp_off[l]   = row.lp_short ? lp_on[l] + SHORT_LP : k[l] + nb - 1;
    end
  // Mid-word packet end only on rows without skew
  pkt_slot = row.pkt_mid ? k[0] + 1 + ( row.n_words / 2 ) * 4 / NUM_LANES + PKT_END_LAG : -1;
  for( int s = 0; s < row_slots( row ); s++ )
    begin
      @( negedge byte_clk );
      for( int l = 0; l < NUM_LANES; l++ )
        begin
          lane_byte_i[l] = slot_byte( l, s, sync_pos[l], nb );
          lp_p_i[l]      = !( s >= lp_on[l] && s < lp_off[l] );
          lp_n_i[l]      = !( s >= lp_on[l] && s < lp_off[l] );
        end
      pkt_end_i = ( s == pkt_slot );
    end
  @( posedge byte_clk );
  check_count( r, words_seen, row.exp_words, "words" );
  check_count( r, skews_seen, row.exp_skew, "skew errors" );
endtask

// Outputs are sampled away from the rising edge
always @( negedge byte_clk )
  begin
    if( word_o.valid === 1'b1 )
      check_word( word_o );
    if( skew_err_o === 1'b1 )
      skews_seen++;
  end

initial
  begin
    arst_n_i    = 1'b0;
    lane_byte_i = '0;
    lp_p_i      = '1;
    lp_n_i      = '1;
    pkt_end_i   = 1'b0;
    rng_state   = SEED;
    repeat( RESET_CYCLES ) @( negedge byte_clk );
    arst_n_i = 1'b1;
    repeat( 4 ) @( negedge byte_clk );
    for( int r = 0; r < NUM_ROWS; r++ )
      apply_row( r );
    $display( "TEST OK" );
    $finish;
  end

initial
  begin
    int total;
    total = 100;
    for( int r = 0; r < NUM_ROWS; r++ )
      total = total + row_slots( row_at( r ) );
    #( total * CLK_PERIOD );
    stop_with_error( "Watchdog expired: the run hung before all rows were applied" );
  end

endmodule

`default_nettype wire

// File: sources.f
dphy_rx_pkg.sv
dphy_settle_ignore.sv
dphy_byte_align.sv
dphy_word_align.sv
dphy_32b_map.sv
dphy_rx_core.sv
tb_dphy_rx_core.sv
